//--- source/tcu_drl_macros.svh
/*
 * Width constants for the dot-product lane
 * FP32 re-biasing constants for FP16, BF16, FP8 and BF8 exponent sums
 */

`ifndef TCU_DRL_MACROS_SVH
`define TCU_DRL_MACROS_SVH

// Operand and product field widths
`define DRL_OP_W   16
`define DRL_EXP_W  8
`define DRL_MANT_W 24
`define DRL_DIFF_W 7

// Added to the raw exponent sum to land in FP32 bias
// 127 - 30 + 1
`define DRL_BIAS_FP16 8'd98
// -127 + 1 in 10-bit two's complement
`define DRL_BIAS_BF16 10'h382
// 127 - 14 + 2
`define DRL_BIAS_FP8  8'd115
// 127 - 30 + 2
`define DRL_BIAS_BF8  8'd99

`endif

//--- source/tcu_drl_pkg.sv
/*
 * Shared types for the dot-product lane
 * Format code enum, operand struct and raw product struct
 */

`include "tcu_drl_macros.svh"

package tcu_drl_pkg;

    // Format codes, values 5 to 7 are illegal
    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,
        FMT_FP16 = 3'd1,
        FMT_BF16 = 3'd2,
        FMT_FP8  = 3'd3,
        FMT_BF8  = 3'd4
    } drl_fmt_e;

    // One operation as accepted by the lane
    typedef struct packed {
        drl_fmt_e              fmt;
        logic [`DRL_OP_W-1:0]  a;
        logic [`DRL_OP_W-1:0]  b;
    } drl_op_t;

    // Raw product in FP32-biased form, mantissa not yet normalized
    typedef struct packed {
        logic                   sign;
        logic [`DRL_EXP_W-1:0]  exp;
        logic [`DRL_MANT_W-1:0] mant;
        logic                   fmt_err;
    } drl_prod_t;

endpackage

//--- source/tcu_drl_exp_bias.sv
/*
 * Exponent path of the lane
 * Adds operand exponents and re-biases them to FP32 for all four formats
 * Also gives the half-sum difference that steers 8-bit mantissa alignment
 */

`timescale 1ns/1ns
`include "tcu_drl_macros.svh"

module tcu_drl_exp_bias import tcu_drl_pkg::*; (
    input  logic                   enable,
    input  drl_fmt_e               fmt,
    input  logic [`DRL_OP_W-1:0]   a,
    input  logic [`DRL_OP_W-1:0]   b,
    output logic [`DRL_EXP_W-1:0]  raw_exp,
    output logic                   exp_low_larger,
    output logic [`DRL_DIFF_W-1:0] raw_exp_diff
);

    logic [`DRL_OP_W-1:0]  gated_a;
    logic [`DRL_OP_W-1:0]  gated_b;
    drl_fmt_e              gated_fmt;

    logic [`DRL_EXP_W-1:0] raw_exp_fp16;

    logic [9:0]            bf16_sum;
    logic [`DRL_EXP_W-1:0] raw_exp_bf16;

    logic [1:0][4:0]       fp8_sum;
    logic [5:0]            fp8_diff;
    logic                  fp8_low_larger;
    logic [4:0]            fp8_max;
    logic [`DRL_EXP_W-1:0] raw_exp_fp8;

    logic [1:0][5:0]       bf8_sum;
    logic [6:0]            bf8_diff;
    logic                  bf8_low_larger;
    logic [5:0]            bf8_max;
    logic [`DRL_EXP_W-1:0] raw_exp_bf8;

    // Hold inputs at zero while idle so the adders do not toggle
    assign gated_a   = a & {`DRL_OP_W{enable}};
    assign gated_b   = b & {`DRL_OP_W{enable}};
    assign gated_fmt = drl_fmt_e'(fmt & {$bits(drl_fmt_e){enable}});

    // FP16 exponents live in bits 14:10
    assign raw_exp_fp16 = {3'd0, gated_a[14:10]} + {3'd0, gated_b[14:10]} + `DRL_BIAS_FP16;

    // BF16 sum can go negative, so it is formed in 10 bits
    assign bf16_sum = {2'd0, gated_a[14:7]} + {2'd0, gated_b[14:7]} + `DRL_BIAS_BF16;

    // Negative sums are reported as their magnitude
    assign raw_exp_bf16 = bf16_sum[9] ? (8'd0 - bf16_sum[7:0]) : bf16_sum[7:0];

    // Per-byte exponent sums, index 1 is the high half
    for (genvar i = 0; i < 2; i++) begin : g_half_sum
        assign fp8_sum[i] = {1'b0, gated_a[i*8+6 -: 4]} + {1'b0, gated_b[i*8+6 -: 4]};
        assign bf8_sum[i] = {1'b0, gated_a[i*8+6 -: 5]} + {1'b0, gated_b[i*8+6 -: 5]};
    end

    // FP8 high minus low, sign bit marks the low half as larger
    assign fp8_diff       = {1'b0, fp8_sum[1]} - {1'b0, fp8_sum[0]};
    assign fp8_low_larger = fp8_diff[5];
    assign fp8_max        = fp8_low_larger ? fp8_sum[0] : fp8_sum[1];
    assign raw_exp_fp8    = {3'd0, fp8_max} + `DRL_BIAS_FP8;

    // BF8 works the same with one more exponent bit
    assign bf8_diff       = {1'b0, bf8_sum[1]} - {1'b0, bf8_sum[0]};
    assign bf8_low_larger = bf8_diff[6];
    assign bf8_max        = bf8_low_larger ? bf8_sum[0] : bf8_sum[1];
    assign raw_exp_bf8    = {2'd0, bf8_max} + `DRL_BIAS_BF8;

    // Output select, unused fields driven to zero
    always_comb begin
        case (gated_fmt)
            FMT_FP16: begin
                raw_exp        = raw_exp_fp16;
                exp_low_larger = 1'b0;
                raw_exp_diff   = '0;
            end
            FMT_BF16: begin
                raw_exp        = raw_exp_bf16;
                exp_low_larger = 1'b0;
                raw_exp_diff   = '0;
            end
            FMT_FP8: begin
                raw_exp        = raw_exp_fp8;
                exp_low_larger = fp8_low_larger;
                // Sign-extend the 6-bit difference
                raw_exp_diff   = {fp8_diff[5], fp8_diff};
            end
            FMT_BF8: begin
                raw_exp        = raw_exp_bf8;
                exp_low_larger = bf8_low_larger;
                raw_exp_diff   = bf8_diff;
            end
            default: begin
                raw_exp        = '0;
                exp_low_larger = 1'b0;
                raw_exp_diff   = '0;
            end
        endcase
    end

    // The mantissa block must see a zero shift for the 16-bit formats
    a_wide_no_low_larger : assert final (
        enable !== 1'b1 ||
        !(gated_fmt === FMT_FP16 || gated_fmt === FMT_BF16) ||
        exp_low_larger === 1'b0
    ) else $error("exp_low_larger set for a 16-bit format");

endmodule

//--- source/tcu_drl_mant_mul.sv
/*
 * Mantissa path of the lane
 * Significand products for all formats, with alignment and signed merge
 * of the two sub-products for FP8 and BF8
 */

`timescale 1ns/1ns
`include "tcu_drl_macros.svh"

module tcu_drl_mant_mul import tcu_drl_pkg::*; (
    input  drl_fmt_e               fmt,
    input  logic [`DRL_OP_W-1:0]   a,
    input  logic [`DRL_OP_W-1:0]   b,
    input  logic                   exp_low_larger,
    input  logic [`DRL_DIFF_W-1:0] raw_exp_diff,
    output logic                   sign,
    output logic [`DRL_MANT_W-1:0] mant
);

    logic [10:0]                  sig_fp16_a;
    logic [10:0]                  sig_fp16_b;
    logic [21:0]                  prod_fp16;
    logic [7:0]                   sig_bf16_a;
    logic [7:0]                   sig_bf16_b;
    logic [15:0]                  prod_bf16;
    logic [1:0][7:0]              prod_fp8;
    logic [1:0][5:0]              prod_bf8;
    logic [1:0]                   half_sign;
    logic [1:0][`DRL_MANT_W-1:0]  half_prod;

    logic [`DRL_MANT_W-1:0]       base_prod;
    logic [`DRL_MANT_W-1:0]       other_prod;
    logic                         base_sign;
    logic                         other_sign;
    logic [`DRL_DIFF_W-1:0]       shamt;
    logic [`DRL_MANT_W-1:0]       shifted;
    logic [`DRL_MANT_W:0]         merged;
    logic [`DRL_MANT_W-1:0]       merged_mag;

    // Hidden bit is 1 unless the exponent field is zero
    assign sig_fp16_a = {|a[14:10], a[9:0]};
    assign sig_fp16_b = {|b[14:10], b[9:0]};
    assign prod_fp16  = sig_fp16_a * sig_fp16_b;

    assign sig_bf16_a = {|a[14:7], a[6:0]};
    assign sig_bf16_b = {|b[14:7], b[6:0]};
    assign prod_bf16  = sig_bf16_a * sig_bf16_b;

    // One sub-product per byte, index 1 is the high half
    for (genvar i = 0; i < 2; i++) begin : g_half_prod
        assign prod_fp8[i] = {|a[i*8+6 -: 4], a[i*8+2 -: 3]} *
                             {|b[i*8+6 -: 4], b[i*8+2 -: 3]};
        assign prod_bf8[i] = {|a[i*8+6 -: 5], a[i*8+1 -: 2]} *
                             {|b[i*8+6 -: 5], b[i*8+1 -: 2]};
        assign half_sign[i] = a[i*8+7] ^ b[i*8+7];

        // Top product bit lands on bit 22
        assign half_prod[i] = (fmt == FMT_FP8) ? {1'b0, prod_fp8[i], 15'd0}
                                               : {1'b0, prod_bf8[i], 17'd0};
    end

    // High half is the base unless the low half has the larger exponent
    assign base_prod  = exp_low_larger ? half_prod[0] : half_prod[1];
    assign base_sign  = exp_low_larger ? half_sign[0] : half_sign[1];
    assign other_prod = exp_low_larger ? half_prod[1] : half_prod[0];
    assign other_sign = exp_low_larger ? half_sign[1] : half_sign[0];

    // Shift by the magnitude of the exponent difference
    assign shamt   = raw_exp_diff[`DRL_DIFF_W-1] ? ('0 - raw_exp_diff) : raw_exp_diff;
    assign shifted = (shamt >= `DRL_DIFF_W'(24)) ? '0 : (other_prod >> shamt);

    // Extra top bit catches a negative result of the subtract
    assign merged = (base_sign == other_sign) ? ({1'b0, base_prod} + {1'b0, shifted})
                                              : ({1'b0, base_prod} - {1'b0, shifted});
    assign merged_mag = merged[`DRL_MANT_W] ? ('0 - merged[`DRL_MANT_W-1:0])
                                            : merged[`DRL_MANT_W-1:0];

    always_comb begin
        case (fmt)
            FMT_FP16: begin
                sign = a[15] ^ b[15];
                mant = {2'd0, prod_fp16};
            end
            FMT_BF16: begin
                sign = a[15] ^ b[15];
                mant = {8'd0, prod_bf16};
            end
            FMT_FP8, FMT_BF8: begin
                sign = base_sign ^ merged[`DRL_MANT_W];
                mant = merged_mag;
            end
            default: begin
                sign = 1'b0;
                mant = '0;
            end
        endcase
    end

    // A carry into bit 23 can only come from an add of like signs
    a_carry_needs_add : assert final (
        !(fmt === FMT_FP8 || fmt === FMT_BF8) ||
        mant[`DRL_MANT_W-1] !== 1'b1 ||
        half_sign[1] == half_sign[0]
    ) else $error("mant bit 23 set after a subtract");

endmodule

//--- source/tcu_drl_lane.sv
/*
 * One lane of the dot-product unit
 * Operand register, exponent and mantissa paths, product register
 * Fixed two-cycle latency with plain valid strobes
 */

`timescale 1ns/1ns
`include "tcu_drl_macros.svh"

module tcu_drl_lane import tcu_drl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  drl_op_t   in_op,
    output logic      out_valid,
    output drl_prod_t out_prod
);

    drl_op_t                op_q;
    logic                   valid_q;

    logic [`DRL_OP_W-1:0]   gated_a;
    logic [`DRL_OP_W-1:0]   gated_b;
    drl_fmt_e               gated_fmt;

    logic [`DRL_EXP_W-1:0]  raw_exp;
    logic                   exp_low_larger;
    logic [`DRL_DIFF_W-1:0] raw_exp_diff;
    logic                   mul_sign;
    logic [`DRL_MANT_W-1:0] mul_mant;

    logic                   fmt_legal;
    drl_prod_t              prod_d;

    // Valid strobes advance every cycle, no stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_q   <= in_valid;
            out_valid <= valid_q;
        end
    end

    // Operand capture
    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_q <= in_op;
        end
    end

    // Idle stage presents zeros to the multipliers
    assign gated_a   = op_q.a & {`DRL_OP_W{valid_q}};
    assign gated_b   = op_q.b & {`DRL_OP_W{valid_q}};
    assign gated_fmt = drl_fmt_e'(op_q.fmt & {$bits(drl_fmt_e){valid_q}});

    tcu_drl_exp_bias u_exp_bias (
        .enable         (valid_q),
        .fmt            (op_q.fmt),
        .a              (op_q.a),
        .b              (op_q.b),
        .raw_exp        (raw_exp),
        .exp_low_larger (exp_low_larger),
        .raw_exp_diff   (raw_exp_diff)
    );

    tcu_drl_mant_mul u_mant_mul (
        .fmt            (gated_fmt),
        .a              (gated_a),
        .b              (gated_b),
        .exp_low_larger (exp_low_larger),
        .raw_exp_diff   (raw_exp_diff),
        .sign           (mul_sign),
        .mant           (mul_mant)
    );

    assign fmt_legal = op_q.fmt inside {FMT_FP16, FMT_BF16, FMT_FP8, FMT_BF8};

    // Illegal codes give an all-zero product with fmt_err set
    always_comb begin
        prod_d = '0;
        if (fmt_legal) begin
            prod_d.sign = mul_sign;
            prod_d.exp  = raw_exp;
            prod_d.mant = mul_mant;
        end else begin
            prod_d.fmt_err = 1'b1;
        end
    end

    // Product holds while idle
    always_ff @(posedge clk) begin
        if (valid_q) begin
            out_prod <= prod_d;
        end
    end

    // Only operations accepted out of reset reach the output
    a_latency_two : assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid & rst_n, 2)
    ) else $error("out_valid does not follow in_valid by two cycles");

    a_valid_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid)
    ) else $error("out_valid unknown");

endmodule

//--- verif/tcu_drl_checker.sv
/*
 * Scoreboard for the dot-product lane
 * Reference model of the lane rules, expectation queue and error counts
 */

`timescale 1ns/1ns

module tcu_drl_checker import tcu_drl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  drl_op_t   in_op,
    input  logic      ref_valid,
    input  drl_prod_t ref_prod,
    input  logic      out_valid,
    input  drl_prod_t out_prod,
    output int        error_count,
    output int        check_count,
    output int        pending
);

    drl_prod_t exp_q [$];
    int        cyc_q [$];
    drl_prod_t expected;
    drl_prod_t model;
    int        accept_cycle;
    int        cycle;

    // Exponent field of one FP8 or BF8 byte with m mantissa bits
    function automatic int byte_exp(input logic [7:0] x, input int m);
        return x[6:0] >> m;
    endfunction

    function automatic int byte_sig(input logic [7:0] x, input int m);
        int frac;
        frac = x[6:0] & ((1 << m) - 1);
        return (byte_exp(x, m) != 0) ? frac + (1 << m) : frac;
    endfunction

    function automatic drl_prod_t model_prod(input drl_op_t op);
        drl_prod_t r;
        int        tmp;
        int        sa;
        int        sb;
        int        m;
        int        bias;
        int        base;
        int        shift;
        int        e_sum [2];
        bit        s [2];
        longint    p [2];
        longint    other;
        longint    res;
        r = '0;
        case (op.fmt)
            FMT_FP16: begin
                tmp    = op.a[14:10] + op.b[14:10] + 98;
                r.exp  = tmp[7:0];
                sa     = (op.a[14:10] != 0 ? 1024 : 0) + op.a[9:0];
                sb     = (op.b[14:10] != 0 ? 1024 : 0) + op.b[9:0];
                tmp    = sa * sb;
                r.mant = tmp[23:0];
                r.sign = op.a[15] ^ op.b[15];
            end
            FMT_BF16: begin
                tmp = op.a[14:7] + op.b[14:7] - 126;
                // Negative sum is reported as its magnitude
                if (tmp < 0) begin
                    tmp = -tmp;
                end
                r.exp  = tmp[7:0];
                sa     = (op.a[14:7] != 0 ? 128 : 0) + op.a[6:0];
                sb     = (op.b[14:7] != 0 ? 128 : 0) + op.b[6:0];
                tmp    = sa * sb;
                r.mant = tmp[23:0];
                r.sign = op.a[15] ^ op.b[15];
            end
            FMT_FP8, FMT_BF8: begin
                m    = (op.fmt == FMT_FP8) ? 3 : 2;
                bias = (op.fmt == FMT_FP8) ? 115 : 99;
                for (int h = 0; h < 2; h++) begin
                    e_sum[h] = byte_exp(op.a[h*8 +: 8], m) + byte_exp(op.b[h*8 +: 8], m);
                    p[h]     = byte_sig(op.a[h*8 +: 8], m) * byte_sig(op.b[h*8 +: 8], m);
                    // Top product bit goes to bit 22
                    p[h]     = p[h] << (23 - 2 * (m + 1));
                    s[h]     = op.a[h*8+7] ^ op.b[h*8+7];
                end
                // Low half is base only when strictly larger
                base   = (e_sum[0] > e_sum[1]) ? 0 : 1;
                shift  = (base == 1) ? e_sum[1] - e_sum[0] : e_sum[0] - e_sum[1];
                other  = (shift >= 24) ? 0 : p[1 - base] >> shift;
                res    = (s[0] == s[1]) ? p[base] + other : p[base] - other;
                r.sign = s[base];
                if (res < 0) begin
                    res    = -res;
                    r.sign = ~s[base];
                end
                r.mant = res[23:0];
                tmp    = e_sum[base] + bias;
                r.exp  = tmp[7:0];
            end
            default: begin
                r.fmt_err = 1'b1;
            end
        endcase
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        if (got !== want) begin
            error_count++;
            $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, want, got);
        end
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        pending     = 0;
        cycle       = 0;
    end

    always @(posedge clk) begin
        if (rst_n !== 1'b1) begin
            cycle = 0;
        end else begin
            cycle++;
            if ($isunknown(out_valid)) begin
                error_count++;
                $display("Error at %0t ns: out_valid is unknown", $time);
            end else if (out_valid) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Error at %0t ns: out_valid high with nothing in flight", $time);
                end else begin
                    expected     = exp_q.pop_front();
                    accept_cycle = cyc_q.pop_front();
                    check_count++;
                    // Accepted at edge N, visible here at edge N+2
                    check_field("out_valid cycle", accept_cycle + 2, cycle);
                    check_field("out_prod.sign", expected.sign, out_prod.sign);
                    check_field("out_prod.exp", expected.exp, out_prod.exp);
                    check_field("out_prod.mant", expected.mant, out_prod.mant);
                    check_field("out_prod.fmt_err", expected.fmt_err, out_prod.fmt_err);
                end
            end
            if (in_valid === 1'b1) begin
                model = model_prod(in_op);
                if (ref_valid === 1'b1) begin
                    if (ref_prod !== model) begin
                        error_count++;
                        $display("Error at %0t ns: table row a=0x%h b=0x%h disagrees with model",
                                 $time, in_op.a, in_op.b);
                    end
                    exp_q.push_back(ref_prod);
                end else begin
                    exp_q.push_back(model);
                end
                cyc_q.push_back(cycle);
            end
            pending = exp_q.size();
        end
    end

endmodule

//--- verif/tcu_drl_tb.sv
/*
 * Testbench for the dot-product lane
 * Clock, reset, directed table with expected products and random phase
 */

`timescale 1ns/1ns
`include "tcu_drl_macros.svh"

module tcu_drl_tb import tcu_drl_pkg::*; ();

    // Stimulus row, expected product follows the operands
    typedef struct packed {
        logic [2:0]           fmt;
        logic [`DRL_OP_W-1:0] a;
        logic [`DRL_OP_W-1:0] b;
        drl_prod_t            prod;
    } row_t;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    drl_op_t   in_op;
    logic      out_valid;
    drl_prod_t out_prod;
    logic      ref_valid;
    drl_prod_t ref_prod;
    int        error_count;
    int        check_count;
    int        pending;
    int        tb_errors;
    row_t      rows [0:17];

    tcu_drl_lane DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .out_valid (out_valid),
        .out_prod  (out_prod)
    );

    tcu_drl_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .ref_valid   (ref_valid),
        .ref_prod    (ref_prod),
        .out_valid   (out_valid),
        .out_prod    (out_prod),
        .error_count (error_count),
        .check_count (check_count),
        .pending     (pending)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic send_op(input drl_op_t op, input logic has_ref, input drl_prod_t want);
        @(posedge clk);
        in_valid  <= 1'b1;
        in_op     <= op;
        ref_valid <= has_ref;
        ref_prod  <= want;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid  <= 1'b0;
        ref_valid <= 1'b0;
    endtask

    initial begin
        int      rnd;
        int      waited;
        drl_op_t op;
        in_valid  = 1'b0;
        in_op     = '0;
        ref_valid = 1'b0;
        ref_prod  = '0;
        rst_n     = 1'b0;
        tb_errors = 0;
        void'($urandom(32'h9b72_a6f0));

        // fmt, a, b, sign, exp, mant, fmt_err
        rows[0]  = {3'd1, 16'h3C00, 16'h4000, 1'b0, 8'h81, 24'h100000, 1'b0};
        rows[1]  = {3'd1, 16'h8001, 16'h3C01, 1'b1, 8'h71, 24'h000401, 1'b0};
        rows[2]  = {3'd1, 16'h7BFF, 16'hFBFF, 1'b1, 8'h9E, 24'h3FF001, 1'b0};
        rows[3]  = {3'd2, 16'h3F80, 16'h4040, 1'b0, 8'h81, 24'h006000, 1'b0};
        rows[4]  = {3'd2, 16'h0080, 16'h8100, 1'b1, 8'h7B, 24'h004000, 1'b0};
        rows[5]  = {3'd2, 16'h0041, 16'h3F80, 1'b0, 8'h01, 24'h002080, 1'b0};
        // FP8 tie, low half larger, shifts of 16 and 28
        rows[6]  = {3'd3, 16'h3838, 16'h3838, 1'b0, 8'h81, 24'h400000, 1'b0};
        rows[7]  = {3'd3, 16'h3848, 16'h3848, 1'b0, 8'h85, 24'h220000, 1'b0};
        rows[8]  = {3'd3, 16'h7838, 16'h7838, 1'b0, 8'h91, 24'h200020, 1'b0};
        rows[9]  = {3'd3, 16'h7808, 16'h7808, 1'b0, 8'h91, 24'h200000, 1'b0};
        // Mixed signs, the first one goes negative
        rows[10] = {3'd3, 16'h38BF, 16'h383F, 1'b1, 8'h81, 24'h508000, 1'b0};
        rows[11] = {3'd3, 16'h4838, 16'h48B8, 1'b0, 8'h85, 24'h1E0000, 1'b0};
        rows[12] = {3'd4, 16'h7C04, 16'h7C04, 1'b0, 8'hA1, 24'h200000, 1'b0};
        rows[13] = {3'd4, 16'h3C40, 16'hBC47, 1'b0, 8'h84, 24'h340000, 1'b0};
        rows[14] = {3'd0, 16'h3C00, 16'h4000, 1'b0, 8'h00, 24'h000000, 1'b1};
        rows[15] = {3'd5, 16'h3838, 16'h3838, 1'b0, 8'h00, 24'h000000, 1'b1};
        rows[16] = {3'd6, 16'h7BFF, 16'h3F80, 1'b0, 8'h00, 24'h000000, 1'b1};
        rows[17] = {3'd7, 16'hFFFF, 16'hFFFF, 1'b0, 8'h00, 24'h000000, 1'b1};

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) idle_cycle();

        // Back to back, so two operations are in flight
        foreach (rows[i]) begin
            op.fmt = drl_fmt_e'(rows[i].fmt);
            op.a   = rows[i].a;
            op.b   = rows[i].b;
            send_op(op, 1'b1, rows[i].prod);
        end
        repeat (2) idle_cycle();

        for (int n = 0; n < 200; n++) begin
            rnd    = $urandom_range(7);
            op.fmt = drl_fmt_e'(rnd[2:0]);
            rnd    = $urandom;
            op.a   = rnd[15:0];
            op.b   = rnd[31:16];
            send_op(op, 1'b0, '0);
            repeat ($urandom_range(2)) idle_cycle();
        end
        idle_cycle();

        waited = 0;
        @(negedge clk);
        while (pending != 0 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            tb_errors++;
            $display("Timeout: %0d results never came out of the lane", pending);
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count + tb_errors);
        if (error_count + tb_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+source
source/tcu_drl_pkg.sv
source/tcu_drl_exp_bias.sv
source/tcu_drl_mant_mul.sv
source/tcu_drl_lane.sv
verif/tcu_drl_checker.sv
verif/tcu_drl_tb.sv

//--- Bender.yml
package:
  name: tcu_drl

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/tcu_drl_pkg.sv
      - source/tcu_drl_exp_bias.sv
      - source/tcu_drl_mant_mul.sv
      - source/tcu_drl_lane.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tcu_drl_checker.sv
      - verif/tcu_drl_tb.sv
